/* sim/busPatterns.hex */
// kind_sBit_cpuSpace_opSize_address_pc_writeData_readData_wait_berr_fc_size_expected
// kind 0 read, 1 write, 2 opcode, 3 read raised with the next opcode line, f ends the list
0_0_0_2_00001000_00000000_00000000_12345678_00_0_1_0_12345678
1_0_0_1_00002004_00000000_cafe0001_00000000_02_0_1_2_00000000
0_1_0_0_00003003_00000000_00000000_a5a50f0f_01_0_5_1_a5a50f0f
1_1_0_2_00004000_00000000_87654321_00000000_00_0_5_0_00000000
0_1_1_2_000ffff0_00000000_00000000_0badf00d_03_0_7_0_0badf00d
1_0_1_1_00020000_00000000_0000beef_00000000_00_0_7_2_00000000
2_0_0_0_00000000_00000100_00000000_4e714e75_00_0_2_2_00004e71
2_1_0_0_00000000_00000102_00000000_4e714e75_02_0_6_2_00004e75
2_0_1_0_00000000_00000206_00000000_11112222_01_0_2_2_00002222
3_0_0_2_00005000_00000000_00000000_deadbeef_0a_0_1_0_deadbeef
2_0_0_0_00000000_00000300_00000000_33334444_00_0_2_2_00003333
0_0_0_2_00006010_00000000_00000000_00000000_01_1_1_0_00006010
0_0_0_1_0000a002_00000000_00000000_01020304_00_0_1_2_01020304
1_1_0_1_00007020_00000000_00000001_00000000_00_1_5_2_00007020
0_0_0_2_00008000_00000000_00000000_00000000_14_0_1_0_00008000
2_1_0_0_00000000_00009002_00000000_00000000_ff_0_6_2_00009002
0_1_0_2_0000d000_00000000_00000000_5555aaaa_0f_0_5_0_5555aaaa
1_0_0_0_0000b001_00000000_000000ff_00000000_08_0_1_1_00000000
2_0_0_0_00000000_0000c000_00000000_60006100_05_0_2_2_00006000
3_1_0_1_0000e002_00000000_00000000_abcd1234_04_0_5_2_abcd1234
2_1_0_0_00000000_0000e00a_00000000_9abcdef0_00_0_6_2_0000def0
f_0_0_0_00000000_00000000_00000000_00000000_00_0_0_0_00000000

/* tb.f */
rtl/busUnitPkg.sv
rtl/accessAttributes.sv
rtl/asyncBusCycle.sv
rtl/busUnitTop.sv
sim/busUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= busUnitTb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASSMSG   ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASSMSG)'

clean:
	rm -rf $(OBJDIR)

/* sim/busUnitTb.sv */
// Bus unit testbench
`timescale 1ns/1ps
`default_nettype none

module busUnitTb
    import busUnitPkg::*;
();

    localparam int busTimeout   = 16;
    localparam int patDepth     = 32;
    localparam int startLimit   = 20;
    localparam int doneLimit    = busTimeout + 8;
    localparam int releaseLimit = 300;

    logic        CLK;
    logic        rstN;
    logic        dataRd;
    logic        dataWr;
    logic        opcodeRd;
    logic [31:0] dataAdr;
    logic [31:0] pc;
    logic [31:0] writeData;
    opSizeT      opSize;
    logic        sBit;
    logic        cpuSpace;
    logic [31:0] busDataIn;
    logic [1:0]  dsackN;
    logic        berrN;
    logic [31:0] adrOut;
    logic [2:0]  fcOut;
    logic [31:0] busDataOut;
    logic        dataEn;
    logic [1:0]  size;
    logic        asN;
    logic        dsN;
    logic        rwN;
    logic        busBusy;
    logic        dataRdy;
    logic        opcodeRdy;
    logic        busError;
    logic [31:0] dataToCore;
    logic [15:0] opcodeToCore;
    logic [31:0] faultAdr;

    // Pattern fields, most significant first
    //   kind, sBit, cpuSpace, opSize, address, pc, writeData, readData,
    //   wait cycles, berr flag, fc, size, expected value
    logic [195:0] pat [patDepth];
    int           slaveQ [$];
    int           errorCount = 0;
    int           testCount  = 0;
    int           failCount  = 0;
    logic [31:0]  rngState   = 32'h7238_b3d8;
    logic [31:0]  lastFault  = '0;
    bit           haveFault  = 1'b0;

    busUnitTop #(
        .busTimeout (busTimeout)
    ) i_busUnitTop (.*);

    initial begin : clockGen
        CLK = 1'b0;
        forever begin
            #50 CLK = ~CLK;
        end
    end

    // ====================
    // Helpers
    // ====================

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string kindName(input logic [3:0] kind);
        case (kind)
            4'd0:    return "read";
            4'd1:    return "write";
            4'd2:    return "opcode";
            4'd3:    return "read+opcode";
            default: return "unknown";
        endcase
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        errorCount++;
    endtask

    task automatic reportFailure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errorCount++;
    endtask

    task automatic setRequest(input logic [3:0] kind, input logic level);
        if (kind == 4'd1)
            dataWr = level;
        else if (kind == 4'd2)
            opcodeRd = level;
        else
            dataRd = level;
    endtask

    task automatic applyLine(input int idx);
        sBit      = pat[idx][188];
        cpuSpace  = pat[idx][184];
        opSize    = opSizeT'(pat[idx][181:180]);
        dataAdr   = pat[idx][179:148];
        pc        = pat[idx][147:116];
        writeData = pat[idx][115:84];
    endtask

    // Follows one bus cycle from strobe to completion and drops its request
    task automatic observeCycle(input int idx);
        logic [3:0]  kind;
        logic [31:0] expAdr;
        logic [31:0] expVal;
        logic [2:0]  expDone;
        logic [2:0]  gotDone;
        bit          isErr;
        bit          early;
        int          waitCnt;
        int          expLat;
        int          lat;
        int          guard;
        kind    = pat[idx][195:192];
        waitCnt = int'(pat[idx][51:44]);
        expVal  = pat[idx][31:0];
        expAdr  = (kind == 4'd2) ? pat[idx][147:116] : pat[idx][179:148];
        isErr   = (pat[idx][43:40] != 4'd0) || (waitCnt >= busTimeout);
        expLat  = (waitCnt >= busTimeout) ? busTimeout + 1 : waitCnt + 2;
        // Order is dataRdy, opcodeRdy, busError
        if (isErr)
            expDone = 3'b001;
        else if (kind == 4'd2)
            expDone = 3'b010;
        else
            expDone = 3'b100;

        guard = 0;
        while (asN && guard < startLimit) begin
            @(negedge CLK);
            guard++;
        end
        if (asN) begin
            reportFailure("bus cycle did not start");
            setRequest(kind, 1'b0);
            return;
        end

        if (dsN !== 1'b0)
            reportMismatch("dsN", 32'(dsN), 32'd0);
        if (adrOut !== expAdr)
            reportMismatch("adrOut", adrOut, expAdr);
        if (32'(fcOut) !== 32'(pat[idx][39:36]))
            reportMismatch("fcOut", 32'(fcOut), 32'(pat[idx][39:36]));
        if (32'(size) !== 32'(pat[idx][35:32]))
            reportMismatch("size", 32'(size), 32'(pat[idx][35:32]));
        if (rwN !== (kind != 4'd1))
            reportMismatch("rwN", 32'(rwN), 32'(kind != 4'd1));
        if (dataEn !== (kind == 4'd1))
            reportMismatch("dataEn", 32'(dataEn), 32'(kind == 4'd1));
        if (kind == 4'd1 && busDataOut !== pat[idx][115:84])
            reportMismatch("busDataOut", busDataOut, pat[idx][115:84]);

        // Strobes must hold until the terminating edge
        lat   = 0;
        early = 1'b0;
        while (!(dataRdy || opcodeRdy || busError) && lat < doneLimit) begin
            if (lat < expLat - 1 && (asN || dsN || !busBusy) && !early) begin
                reportFailure("strobes released before termination");
                early = 1'b1;
            end
            @(negedge CLK);
            lat++;
        end
        if (!(dataRdy || opcodeRdy || busError)) begin
            reportFailure("no completion pulse within the bus monitor limit");
            setRequest(kind, 1'b0);
            return;
        end

        if (lat != expLat)
            reportMismatch("completion latency", 32'(lat), 32'(expLat));
        gotDone = {dataRdy, opcodeRdy, busError};
        if (gotDone !== expDone)
            reportMismatch("completion flags", 32'(gotDone), 32'(expDone));
        if (!asN || !dsN || busBusy || dataEn)
            reportFailure("bus still active in the completion cycle");
        if (isErr) begin
            if (faultAdr !== expVal)
                reportMismatch("faultAdr", faultAdr, expVal);
            lastFault = expVal;
            haveFault = 1'b1;
        end else begin
            if (haveFault && faultAdr !== lastFault)
                reportMismatch("faultAdr held", faultAdr, lastFault);
            if (kind == 4'd2 && opcodeToCore !== expVal[15:0])
                reportMismatch("opcodeToCore", 32'(opcodeToCore), expVal);
            if ((kind == 4'd0 || kind == 4'd3) && dataToCore !== expVal)
                reportMismatch("dataToCore", dataToCore, expVal);
        end
        setRequest(kind, 1'b0);
    endtask

    // ====================
    // Bus slave
    // ====================

    // Answers each strobe with the next queued pattern line
    initial begin : slaveModel
        int idx;
        int cnt;
        int guard;
        busDataIn = '0;
        dsackN    = 2'b11;
        berrN     = 1'b1;
        forever begin
            @(negedge CLK);
            if (rstN && !asN) begin
                idx = -1;
                if (slaveQ.size() == 0)
                    reportFailure("bus cycle started with no transaction queued");
                else
                    idx = slaveQ.pop_front();
                if (idx >= 0) begin
                    cnt = 0;
                    while (!asN && cnt < int'(pat[idx][51:44])) begin
                        @(negedge CLK);
                        cnt++;
                    end
                    // Skipped when the bus monitor already ended the cycle
                    if (!asN) begin
                        busDataIn = pat[idx][83:52];
                        if (pat[idx][43:40] != 4'd0)
                            berrN = 1'b0;
                        else
                            dsackN = 2'b00;
                    end
                end
                guard = 0;
                while (!asN && guard < releaseLimit) begin
                    @(negedge CLK);
                    guard++;
                end
                if (!asN)
                    reportFailure("asN stuck low at the bus slave");
                dsackN = 2'b11;
                berrN  = 1'b1;
            end
        end
    end

    // ====================
    // Test sequence
    // ====================

    initial begin : mainSeq
        int idx;
        int gap;
        int step;
        int errBefore;
        rstN      = 1'b0;
        dataRd    = 1'b0;
        dataWr    = 1'b0;
        opcodeRd  = 1'b0;
        dataAdr   = '0;
        pc        = '0;
        writeData = '0;
        opSize    = opLong;
        sBit      = 1'b0;
        cpuSpace  = 1'b0;
        $readmemh("sim/busPatterns.hex", pat);
        repeat (16) @(negedge CLK);
        rstN = 1'b1;
        @(negedge CLK);

        idx = 0;
        while (idx < patDepth && pat[idx][195:192] != 4'hf) begin
            rngState = nextRandom(rngState);
            gap      = int'(rngState[31:30]);
            repeat (gap) @(negedge CLK);
            errBefore = errorCount;
            applyLine(idx);
            if (pat[idx][195:192] == 4'd3) begin
                // Data read and opcode fetch raised on the same edge
                pc = pat[idx + 1][147:116];
                slaveQ.push_back(idx);
                slaveQ.push_back(idx + 1);
                dataRd   = 1'b1;
                opcodeRd = 1'b1;
                observeCycle(idx);
                sBit     = pat[idx + 1][188];
                cpuSpace = pat[idx + 1][184];
                observeCycle(idx + 1);
                step = 2;
            end else begin
                slaveQ.push_back(idx);
                setRequest(pat[idx][195:192], 1'b1);
                observeCycle(idx);
                step = 1;
            end
            testCount++;
            if (errorCount != errBefore)
                failCount++;
            $display("test %0d %s %s", testCount, kindName(pat[idx][195:192]),
                     (errorCount == errBefore) ? "ok" : "FAILED");
            idx += step;
        end

        if (testCount == 0)
            reportFailure("no transactions read from the pattern file");
        $display("tests %0d, failed %0d, errors %0d", testCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/busUnitTop.sv */
// Bus unit top level
`timescale 1ns/1ps
`default_nettype none

module busUnitTop
    import busUnitPkg::*;
#(
    parameter int busTimeout = 16
) (
    input  logic        CLK,
    input  logic        rstN,
    input  logic        dataRd,
    input  logic        dataWr,
    input  logic        opcodeRd,
    input  logic [31:0] dataAdr,
    input  logic [31:0] pc,
    input  logic [31:0] writeData,
    input  opSizeT      opSize,
    input  logic        sBit,
    input  logic        cpuSpace,
    input  logic [31:0] busDataIn,
    input  logic [1:0]  dsackN,
    input  logic        berrN,
    output logic [31:0] adrOut,
    output logic [2:0]  fcOut,
    output logic [31:0] busDataOut,
    output logic        dataEn,
    output logic [1:0]  size,
    output logic        asN,
    output logic        dsN,
    output logic        rwN,
    output logic        busBusy,
    output logic        dataRdy,
    output logic        opcodeRdy,
    output logic        busError,
    output logic [31:0] dataToCore,
    output logic [15:0] opcodeToCore,
    output logic [31:0] faultAdr
);

    logic        startRd;
    logic        startWr;
    logic        startOpcode;
    logic [31:0] busAdr;
    logic [2:0]  busFc;
    logic        cycleDone;
    logic        errorEnd;

    // Request priority and attribute latching
    accessAttributes i_accessAttributes (
        .CLK         (CLK),
        .rstN        (rstN),
        .dataRd      (dataRd),
        .dataWr      (dataWr),
        .opcodeRd    (opcodeRd),
        .dataAdr     (dataAdr),
        .pc          (pc),
        .sBit        (sBit),
        .cpuSpace    (cpuSpace),
        .busBusy     (busBusy),
        .cycleDone   (cycleDone),
        .errorEnd    (errorEnd),
        .startRd     (startRd),
        .startWr     (startWr),
        .startOpcode (startOpcode),
        .busAdr      (busAdr),
        .busFc       (busFc),
        .faultAdr    (faultAdr)
    );

    // Strobes, termination and bus monitor
    asyncBusCycle #(
        .busTimeout (busTimeout)
    ) i_asyncBusCycle (
        .CLK          (CLK),
        .rstN         (rstN),
        .startRd      (startRd),
        .startWr      (startWr),
        .startOpcode  (startOpcode),
        .busAdr       (busAdr),
        .busFc        (busFc),
        .opSize       (opSize),
        .writeData    (writeData),
        .busDataIn    (busDataIn),
        .dsackN       (dsackN),
        .berrN        (berrN),
        .adrOut       (adrOut),
        .fcOut        (fcOut),
        .size         (size),
        .asN          (asN),
        .dsN          (dsN),
        .rwN          (rwN),
        .dataEn       (dataEn),
        .busDataOut   (busDataOut),
        .busBusy      (busBusy),
        .cycleDone    (cycleDone),
        .errorEnd     (errorEnd),
        .dataRdy      (dataRdy),
        .opcodeRdy    (opcodeRdy),
        .busError     (busError),
        .dataToCore   (dataToCore),
        .opcodeToCore (opcodeToCore)
    );

endmodule

`default_nettype wire

/* rtl/asyncBusCycle.sv */
// Asynchronous bus cycle
`timescale 1ns/1ps
`default_nettype none

module asyncBusCycle
    import busUnitPkg::*;
#(
    parameter int busTimeout = 16
) (
    input  logic        CLK,
    input  logic        rstN,
    input  logic        startRd,
    input  logic        startWr,
    input  logic        startOpcode,
    input  logic [31:0] busAdr,
    input  logic [2:0]  busFc,
    input  opSizeT      opSize,
    input  logic [31:0] writeData,
    input  logic [31:0] busDataIn,
    input  logic [1:0]  dsackN,
    input  logic        berrN,
    output logic [31:0] adrOut,
    output logic [2:0]  fcOut,
    output logic [1:0]  size,
    output logic        asN,
    output logic        dsN,
    output logic        rwN,
    output logic        dataEn,
    output logic [31:0] busDataOut,
    output logic        busBusy,
    output logic        cycleDone,
    output logic        errorEnd,
    output logic        dataRdy,
    output logic        opcodeRdy,
    output logic        busError,
    output logic [31:0] dataToCore,
    output logic [15:0] opcodeToCore
);

    localparam int cntW = $clog2(busTimeout);

    typedef enum logic [1:0] {stIdle, stStrobe, stDone} stateT;

    stateT           state;
    logic [cntW-1:0] strobeCnt;
    logic            opFetch;
    logic            startAny;
    logic            dsackSeen;
    logic            timedOut;
    logic            errNow;
    logic [1:0]      sizeCode;
    busWordU         rdWord;

    assign startAny  = startRd || startWr || startOpcode;
    assign dsackSeen = (dsackN != 2'b11);
    // Last strobe cycle that the bus monitor allows
    assign timedOut  = (strobeCnt == cntW'(busTimeout - 1));
    // BERRn wins over DSACKn on the same edge
    assign errNow    = !berrN || (!dsackSeen && timedOut);

    always_comb begin : sizeEncode
        case (opSize)
            opByte:  sizeCode = sizeByte;
            opWord:  sizeCode = sizeWord;
            default: sizeCode = sizeLong;
        endcase
    end

    // ====================
    // Cycle FSM
    // ====================

    always_ff @(posedge CLK) begin : cycleFsm
        if (!rstN) begin
            state     <= stIdle;
            strobeCnt <= '0;
            asN       <= 1'b1;
            dsN       <= 1'b1;
            rwN       <= 1'b1;
            dataEn    <= 1'b0;
            errorEnd  <= 1'b0;
            dataRdy   <= 1'b0;
            opcodeRdy <= 1'b0;
            busError  <= 1'b0;
        end else begin
            dataRdy   <= 1'b0;
            opcodeRdy <= 1'b0;
            busError  <= 1'b0;
            case (state)
                stIdle: begin
                    if (startAny) begin
                        state     <= stStrobe;
                        strobeCnt <= '0;
                        asN       <= 1'b0;
                        dsN       <= 1'b0;
                        rwN       <= !startWr;
                        dataEn    <= startWr;
                    end
                end
                stStrobe: begin
                    if (dsackSeen || errNow) begin
                        state    <= stDone;
                        asN      <= 1'b1;
                        dsN      <= 1'b1;
                        rwN      <= 1'b1;
                        dataEn   <= 1'b0;
                        errorEnd <= errNow;
                    end else begin
                        strobeCnt <= strobeCnt + 1'b1;
                    end
                end
                stDone: begin
                    // Completion pulse follows the strobes by one cycle
                    state     <= stIdle;
                    dataRdy   <= !errorEnd && !opFetch;
                    opcodeRdy <= !errorEnd && opFetch;
                    busError  <= errorEnd;
                end
                default: state <= stIdle;
            endcase
        end
    end

    // Bus attributes for the whole cycle
    always_ff @(posedge CLK) begin : attrLatch
        if (state == stIdle && startAny) begin
            adrOut     <= busAdr;
            fcOut      <= busFc;
            size       <= startOpcode ? sizeWord : sizeCode;
            busDataOut <= writeData;
            opFetch    <= startOpcode;
        end
    end

    // Read data is taken on the terminating edge
    always_ff @(posedge CLK) begin : readCapture
        if (state == stStrobe && dsackSeen && !errNow && rwN) begin
            rdWord.longWord <= busDataIn;
        end
    end

    assign busBusy      = (state != stIdle);
    assign cycleDone    = (state == stDone);
    assign dataToCore   = rdWord.longWord;
    // Even word address selects the upper half
    assign opcodeToCore = rdWord.opWord[!adrOut[1]];

    // ====================
    // Checks
    // ====================

    dsInsideAs: assert property (@(posedge CLK) disable iff (!rstN)
        !dsN |-> !asN);

    oneCompletion: assert property (@(posedge CLK) disable iff (!rstN)
        $onehot0({dataRdy, opcodeRdy, busError}));

endmodule

`default_nettype wire

/* rtl/accessAttributes.sv */
// Bus access attributes
`timescale 1ns/1ps
`default_nettype none

module accessAttributes
    import busUnitPkg::*;
(
    input  logic        CLK,
    input  logic        rstN,

    // Request levels from the core
    input  logic        dataRd,
    input  logic        dataWr,
    input  logic        opcodeRd,
    input  logic [31:0] dataAdr,
    input  logic [31:0] pc,
    input  logic        sBit,
    input  logic        cpuSpace,

    // Status from the bus cycle
    input  logic        busBusy,
    input  logic        cycleDone,
    input  logic        errorEnd,

    // Cycle start and latched attributes
    output logic        startRd,
    output logic        startWr,
    output logic        startOpcode,
    output logic [31:0] busAdr,
    output logic [2:0]  busFc,
    output logic [31:0] faultAdr
);

    logic       startAny;
    logic       idle;
    logic       dataReq;
    logic       anyReq;
    logic [2:0] fcSel;

    assign startAny = startRd || startWr || startOpcode;

    // A start pulse in flight counts as busy, the FSM only sees it one edge later
    assign idle    = !busBusy && !startAny;
    assign dataReq = dataRd || dataWr;
    assign anyReq  = dataReq || opcodeRd;

    // ====================
    // Function code
    // ====================

    always_comb begin : fcSelect
        if (dataReq && cpuSpace) begin
            fcSel = fcCpuSpace;
        end else if (dataReq && sBit) begin
            fcSel = fcSuperData;
        end else if (dataReq) begin
            fcSel = fcUserData;
        end else if (sBit) begin
            fcSel = fcSuperProg;
        end else begin
            fcSel = fcUserProg;
        end
    end

    // ====================
    // Request sampling
    // ====================

    // Data beats opcode, read beats write
    always_ff @(posedge CLK) begin : startPulse
        if (!rstN) begin
            startRd     <= 1'b0;
            startWr     <= 1'b0;
            startOpcode <= 1'b0;
        end else begin
            startRd     <= idle && dataRd;
            startWr     <= idle && dataWr && !dataRd;
            startOpcode <= idle && opcodeRd && !dataReq;
        end
    end

    // Address and FC are taken on the same edge as the start pulse
    always_ff @(posedge CLK) begin : adrFcLatch
        if (idle && anyReq) begin
            busAdr <= dataReq ? dataAdr : pc;
            busFc  <= fcSel;
        end
    end

    // Address of the last cycle that ended in a bus error
    always_ff @(posedge CLK) begin : faultLatch
        if (cycleDone && errorEnd) begin
            faultAdr <= busAdr;
        end
    end

    // ====================
    // Checks
    // ====================

    // The FSM only takes a start while idle, so a second one would be dropped
    startOneHot: assert property (@(posedge CLK) disable iff (!rstN)
        $onehot0({startRd, startWr, startOpcode}));

    startWhileBusy: assert property (@(posedge CLK) disable iff (!rstN)
        busBusy |-> !startAny);

endmodule

`default_nettype wire

/* rtl/busUnitPkg.sv */
// Bus unit shared definitions
`default_nettype none

package busUnitPkg;

    // ====================
    // Operand size
    // ====================

    // Size of a data access as requested by the core
    typedef enum logic [1:0] {
        opByte = 2'b00,
        opWord = 2'b01,
        opLong = 2'b10
    } opSizeT;

    // SIZE pin encodings, 68K convention
    localparam logic [1:0] sizeByte = 2'b01;
    localparam logic [1:0] sizeWord = 2'b10;
    localparam logic [1:0] sizeLong = 2'b00;

    // ====================
    // Function codes
    // ====================

    localparam logic [2:0] fcUserData  = 3'd1;
    localparam logic [2:0] fcUserProg  = 3'd2;
    localparam logic [2:0] fcSuperData = 3'd5;
    localparam logic [2:0] fcSuperProg = 3'd6;
    localparam logic [2:0] fcCpuSpace  = 3'd7;

    // ====================
    // Bus word
    // ====================

    // One longword off the 32-bit port, seen as data or as two opcode words.
    // Word 1 is the upper half, which sits at the lower byte address
    typedef union packed {
        logic [31:0]      longWord;
        logic [1:0][15:0] opWord;
    } busWordU;

endpackage

`default_nettype wire
